// File: hw/mera_pkg.sv
// mera-400 control path shared definitions
// word and field types, opcodes, sequencer states and w bus encodings
`default_nettype none

package mera_pkg;

	// data, address and instruction word
	typedef logic [15:0] word_t;

	// general register number
	typedef logic [2:0] reg_sel_t;

	// major opcode, instruction bits 15..10
	typedef logic [5:0] opcode_t;

	// size of the general register file
	localparam int reg_count = 8;

	// executed opcodes
	localparam opcode_t op_lw  = 6'o20;
	localparam opcode_t op_aw  = 6'o40;
	localparam opcode_t op_nr  = 6'o46;
	localparam opcode_t op_er  = 6'o50;
	localparam opcode_t op_uj  = 6'o70;
	localparam opcode_t op_hlt = 6'o73;

	// sequencer states
	typedef enum logic [2:0] {
		st_wait,
		st_fetch,
		st_arg,
		st_rc,
		st_bmod,
		st_exec
	} seq_state_t;

	// w bus source grant
	typedef enum logic [1:0] {
		src_ki,
		src_reg,
		src_alu,
		src_ac
	} w_src_t;

	// alu operation
	typedef enum logic [1:0] {
		alu_pass,
		alu_add,
		alu_and,
		alu_xor
	} alu_op_t;

endpackage

`default_nettype wire

// File: hw/ctl_seq.sv
// microinstruction sequencer of the p-m unit
// decodes the instruction, grants the w bus and issues microoperation strobes
`timescale 1ns/1ps
`default_nettype none

module ctl_seq (
	input  wire                __wls_1,
	input  wire                __m77,
	input  wire                start,
	input  wire                ok,
	input  wire mera_pkg::word_t ki,
	output logic               rd,
	output logic               run,
	output mera_pkg::w_src_t   w_src,
	output mera_pkg::alu_op_t  alu_op,
	output mera_pkg::reg_sel_t rsel,
	output logic               w_r,
	output logic               w_ic,
	output logic               w_ac,
	output logic               ic_inc,
	output logic               ki_take
);
	import mera_pkg::*;

	seq_state_t state;
	word_t      ir;
	logic       pend;
	logic       got;
	logic       w_ir;
	opcode_t    opc;
	reg_sel_t   fa;
	reg_sel_t   fb;
	reg_sel_t   fc;

	// instruction fields, d bit ignored
	assign opc = ir[15:10];
	assign fa  = ir[8:6];
	assign fb  = ir[5:3];
	assign fc  = ir[2:0];

	// got marks the cycle after ok, KI holds the new word
	assign ki_take = got;

	// one read per fetch or argument step
	assign rd = ((state == st_fetch) || (state == st_arg)) && !pend && !got;

	// w bus grant and strobes, one source per cycle
	always_comb begin
		w_src  = src_ac;
		alu_op = alu_pass;
		rsel   = fa;
		w_r    = 1'b0;
		w_ic   = 1'b0;
		w_ac   = 1'b0;
		ic_inc = 1'b0;
		w_ir   = 1'b0;
		case (state)
			st_fetch: begin
				if (got) begin
					w_ir   = 1'b1;
					ic_inc = 1'b1;
				end
			end
			st_arg: begin
				// second word straight from KI into AC
				if (got) begin
					w_src  = src_ki;
					w_ac   = 1'b1;
					ic_inc = 1'b1;
				end
			end
			st_rc: begin
				w_src = src_reg;
				rsel  = fc;
				w_ac  = 1'b1;
			end
			st_bmod: begin
				w_src  = src_alu;
				alu_op = alu_add;
				rsel   = fb;
				w_ac   = 1'b1;
			end
			st_exec: begin
				case (opc)
					op_lw: w_r = 1'b1;
					op_aw: begin
						w_src  = src_alu;
						alu_op = alu_add;
						w_r    = 1'b1;
					end
					op_nr: begin
						w_src  = src_alu;
						alu_op = alu_and;
						w_r    = 1'b1;
					end
					op_er: begin
						w_src  = src_alu;
						alu_op = alu_xor;
						w_r    = 1'b1;
					end
					op_uj: w_ic = 1'b1;
					default: ;
				endcase
			end
			default: ;
		endcase
	end

	always_ff @(posedge __wls_1 or posedge __m77) begin
		if (__m77) begin
			state <= st_wait;
			ir    <= '0;
			pend  <= 1'b0;
			got   <= 1'b0;
			run   <= 1'b0;
		end else begin
			if (rd)
				pend <= 1'b1;
			if (pend && ok) begin
				pend <= 1'b0;
				got  <= 1'b1;
			end
			if (got)
				got <= 1'b0;
			if (w_ir)
				ir <= ki;
			case (state)
				st_wait: begin
					if (start) begin
						run   <= 1'b1;
						state <= st_fetch;
					end
				end
				// c field taken from KI, IR loads on the same edge
				st_fetch: begin
					if (got)
						state <= (ki[2:0] == 3'd0) ? st_arg : st_rc;
				end
				st_arg: begin
					if (got)
						state <= (fb != 3'd0) ? st_bmod : st_exec;
				end
				st_rc:   state <= (fb != 3'd0) ? st_bmod : st_exec;
				st_bmod: state <= st_exec;
				st_exec: begin
					if (opc == op_hlt) begin
						run   <= 1'b0;
						state <= st_wait;
					end else begin
						state <= st_fetch;
					end
				end
				default: state <= st_wait;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/reg_file.sv
// general register file, r0..r7
// combinational read of the selected register, write from the w bus
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  wire                  __wls_1,
	input  wire                  __m77,
	input  wire                  w_r,
	input  wire mera_pkg::reg_sel_t rsel,
	input  wire mera_pkg::word_t w_bus,
	output mera_pkg::word_t      rdata
);
	import mera_pkg::*;

	word_t regs [reg_count];

	assign rdata = regs[rsel];

	always_ff @(posedge __wls_1 or posedge __m77) begin
		if (__m77) begin
			for (int i = 0; i < reg_count; i++)
				regs[i] <= '0;
		end else if (w_r) begin
			regs[rsel] <= w_bus;
		end
	end

endmodule

`default_nettype wire

// File: hw/alu.sv
// argument register AC and the result logic
// AC combined with the register read port by pass, add, and or xor
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  wire                   __wls_1,
	input  wire                   __m77,
	input  wire                   w_ac,
	input  wire mera_pkg::alu_op_t alu_op,
	input  wire mera_pkg::word_t  w_bus,
	input  wire mera_pkg::word_t  rdata,
	output mera_pkg::word_t       ac,
	output mera_pkg::word_t       result
);
	import mera_pkg::*;

	always_ff @(posedge __wls_1 or posedge __m77) begin
		if (__m77)
			ac <= '0;
		else if (w_ac)
			ac <= w_bus;
	end

	// add wraps modulo 2^16, carry dropped
	always_comb begin
		case (alu_op)
			alu_add: result = ac + rdata;
			alu_and: result = ac & rdata;
			alu_xor: result = ac ^ rdata;
			default: result = ac;
		endcase
	end

endmodule

`default_nettype wire

// File: hw/ic_ar.sv
// instruction counter IC, doubling as address register AR
// loads from the w bus or steps by one, drives the memory address
`timescale 1ns/1ps
`default_nettype none

module ic_ar (
	input  wire                  __wls_1,
	input  wire                  __m77,
	input  wire                  w_ic,
	input  wire                  ic_inc,
	input  wire mera_pkg::word_t w_bus,
	output mera_pkg::word_t      addr
);
	import mera_pkg::*;

	word_t ic;

	// no data reads, so AR always equals IC
	assign addr = ic;

	always_ff @(posedge __wls_1 or posedge __m77) begin
		if (__m77)
			ic <= '0;
		else if (w_ic)
			ic <= w_bus;
		else if (ic_inc)
			ic <= ic + 16'd1;
	end

endmodule

`default_nettype wire

// File: hw/w_bus_sel.sv
// KI memory data latch and the w bus driver
// w bus follows the source granted by the sequencer
`timescale 1ns/1ps
`default_nettype none

module w_bus_sel (
	input  wire                   __wls_1,
	input  wire                   __m77,
	input  wire                   ok,
	input  wire mera_pkg::word_t  data_in,
	input  wire mera_pkg::w_src_t w_src,
	input  wire mera_pkg::word_t  rdata,
	input  wire mera_pkg::word_t  result,
	input  wire mera_pkg::word_t  ac,
	output mera_pkg::word_t       ki,
	output mera_pkg::word_t       w_bus
);
	import mera_pkg::*;

	// memory word valid only in the ok cycle
	always_ff @(posedge __wls_1 or posedge __m77) begin
		if (__m77)
			ki <= '0;
		else if (ok)
			ki <= data_in;
	end

	always_comb begin
		case (w_src)
			src_ki:  w_bus = ki;
			src_reg: w_bus = rdata;
			src_alu: w_bus = result;
			default: w_bus = ac;
		endcase
	end

endmodule

`default_nettype wire

// File: hw/cpu_top.sv
// cut-down mera-400 control path
// sequencer with register file, alu, IC and w bus peers on a strobe memory port
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
	input  wire                  __wls_1,
	input  wire                  __m77,
	input  wire                  start,
	input  wire                  ok,
	input  wire mera_pkg::word_t data_in,
	output wire                  rd,
	output wire mera_pkg::word_t addr,
	output wire                  run,
	output wire                  w_r,
	output wire                  w_ic,
	output wire mera_pkg::reg_sel_t rsel,
	output wire mera_pkg::word_t w_bus
);
	import mera_pkg::*;

	w_src_t  w_src;
	alu_op_t alu_op;
	wire     w_ac;
	wire     ic_inc;
	word_t   ki;
	word_t   rdata;
	word_t   result;
	word_t   ac;

	// KI take strobe stays inside the sequencer, the latch runs on ok
	ctl_seq u_ctl_seq (
		.__wls_1 (__wls_1),
		.__m77   (__m77),
		.start   (start),
		.ok      (ok),
		.ki      (ki),
		.rd      (rd),
		.run     (run),
		.w_src   (w_src),
		.alu_op  (alu_op),
		.rsel    (rsel),
		.w_r     (w_r),
		.w_ic    (w_ic),
		.w_ac    (w_ac),
		.ic_inc  (ic_inc),
		.ki_take ()
	);

	reg_file u_reg_file (
		.__wls_1 (__wls_1),
		.__m77   (__m77),
		.w_r     (w_r),
		.rsel    (rsel),
		.w_bus   (w_bus),
		.rdata   (rdata)
	);

	alu u_alu (
		.__wls_1 (__wls_1),
		.__m77   (__m77),
		.w_ac    (w_ac),
		.alu_op  (alu_op),
		.w_bus   (w_bus),
		.rdata   (rdata),
		.ac      (ac),
		.result  (result)
	);

	ic_ar u_ic_ar (
		.__wls_1 (__wls_1),
		.__m77   (__m77),
		.w_ic    (w_ic),
		.ic_inc  (ic_inc),
		.w_bus   (w_bus),
		.addr    (addr)
	);

	w_bus_sel u_w_bus_sel (
		.__wls_1 (__wls_1),
		.__m77   (__m77),
		.ok      (ok),
		.data_in (data_in),
		.w_src   (w_src),
		.rdata   (rdata),
		.result  (result),
		.ac      (ac),
		.ki      (ki),
		.w_bus   (w_bus)
	);

endmodule

`default_nettype wire

// File: dv/tb_cpu.sv
// testbench for the cut-down mera-400 control path
// random program memory, memory responder and a reference model of registers and IC
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;
	import mera_pkg::*;

	localparam int clk_period = 10;
	localparam int reset_cycles = 5;
	localparam int idle_cycles = 20;
	localparam int n_instr = 400;
	localparam logic [31:0] seed = 32'h71b83667;
	// strobe patterns as {w_ic, w_r, rd}
	localparam logic [2:0] ev_rd = 3'b001;
	localparam logic [2:0] ev_wr = 3'b010;
	localparam logic [2:0] ev_wic = 3'b100;

	logic     __wls_1;
	logic     __m77;
	logic     start;
	logic     ok;
	word_t    data_in;
	logic     rd;
	word_t    addr;
	logic     run;
	logic     w_r;
	logic     w_ic;
	reg_sel_t rsel;
	word_t    w_bus;

	word_t       mem [256];
	word_t       model_regs [reg_count];
	word_t       model_ic;
	int          cov [9];
	string       cov_names [9] = '{"lw", "aw", "nr", "er", "uj", "hlt",
		"undefined opcode", "long form", "b-modified"};
	int          checks;
	int          errors;
	int          tests;
	int          test_checks;
	int          test_errors;
	string       cur_test;
	int unsigned seed_val;

	cpu_top uut (
		.__wls_1 (__wls_1),
		.__m77   (__m77),
		.start   (start),
		.ok      (ok),
		.data_in (data_in),
		.rd      (rd),
		.addr    (addr),
		.run     (run),
		.w_r     (w_r),
		.w_ic    (w_ic),
		.rsel    (rsel),
		.w_bus   (w_bus)
	);

	initial begin
		__wls_1 = 1'b0;
		forever #(clk_period / 2) __wls_1 = ~__wls_1;
	end

	// 20 cycles per instruction plus reset and idle time
	initial begin
		#((n_instr * 20 + reset_cycles + idle_cycles + 50) * clk_period);
		$display("Timeout: the program run did not finish within its cycle budget");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	// memory answers each rd with ok after 1 to 4 cycles
	initial begin
		int    lat;
		word_t a;
		ok = 1'b0;
		data_in = '0;
		forever begin
			@(negedge __wls_1);
			if (rd) begin
				a = addr;
				lat = $urandom_range(1, 4);
				repeat (lat) @(posedge __wls_1);
				ok <= 1'b1;
				data_in <= mem[a[7:0]];
				@(posedge __wls_1);
				ok <= 1'b0;
				data_in <= '0;
			end
		end
	end

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("Mismatch %s, %s: expected %0h, actual %0h", cur_test, name,
				expected, actual);
		end
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		test_checks = checks;
		test_errors = errors;
	endtask

	task automatic end_test();
		tests++;
		$display("test %s finished: %0d checks, %0d errors", cur_test, checks - test_checks,
			errors - test_errors);
	endtask

	function automatic opcode_t pick_opcode();
		case ($urandom_range(0, 9))
			0, 1: return op_lw;
			2: return op_aw;
			3: return op_nr;
			4: return op_er;
			5: return op_uj;
			6: return op_hlt;
			7: return 6'o01;
			8: return 6'o21;
			default: return 6'o77;
		endcase
	endfunction

	task automatic build_program();
		int       a;
		int       t;
		int       starts [$];
		int       uj_arg [$];
		int       uj_pos [$];
		opcode_t  opc;
		logic     d;
		reg_sel_t fa;
		reg_sel_t fb;
		reg_sel_t fc;
		a = 0;
		while (a < 256) begin
			opc = pick_opcode();
			d = 1'($urandom_range(0, 1));
			fa = 3'($urandom_range(0, 7));
			fb = 3'($urandom_range(0, 7));
			fc = 3'($urandom_range(0, 7));
			// jumps take the long form without B-modification
			if (opc == op_uj) begin
				fb = 3'd0;
				fc = 3'd0;
			end
			// no second word past the end of memory
			if (a == 255) begin
				if (opc == op_uj)
					opc = op_lw;
				if (fc == 3'd0)
					fc = 3'd1;
			end
			if (opc == op_uj) begin
				uj_arg.push_back(a + 1);
				uj_pos.push_back(starts.size());
			end
			starts.push_back(a);
			mem[a] = {opc, d, fa, fb, fc};
			a++;
			if (fc == 3'd0) begin
				mem[a] = 16'($urandom);
				a++;
			end
		end
		// short forward jumps onto instruction words, the last ones wrap to 0
		foreach (uj_arg[i]) begin
			t = uj_pos[i] + $urandom_range(1, 8);
			mem[uj_arg[i]] = (t < starts.size()) ? 16'(starts[t]) : 16'd0;
		end
	endtask

	task automatic wait_strobe(output logic [2:0] ev);
		ev = 3'b000;
		while (ev == 3'b000) begin
			@(negedge __wls_1);
			ev = {w_ic, w_r, rd};
		end
	endtask

	task automatic read_check(input string tag, input word_t exp_addr);
		logic [2:0] ev;
		wait_strobe(ev);
		compare({tag, " read strobe"}, ev_rd, ev);
		compare({tag, " read addr"}, exp_addr, addr);
		compare({tag, " run"}, 1, run);
	endtask

	task automatic reg_write_check(input string tag, input reg_sel_t ra, input word_t val);
		logic [2:0] ev;
		wait_strobe(ev);
		compare({tag, " write strobe"}, ev_wr, ev);
		compare({tag, " rsel"}, ra, rsel);
		compare({tag, " w_bus"}, val, w_bus);
		model_regs[ra] = val;
	endtask

	task automatic jump_check(input string tag, input word_t target);
		logic [2:0] ev;
		wait_strobe(ev);
		compare({tag, " jump strobe"}, ev_wic, ev);
		compare({tag, " w_bus"}, target, w_bus);
		model_ic = target;
	endtask

	// one-cycle start level, seen in st_wait on the following edge
	task automatic raise_start();
		@(posedge __wls_1);
		start <= 1'b1;
		@(posedge __wls_1);
		start <= 1'b0;
	endtask

	task automatic halt_and_resume(input string tag);
		int c;
		int pause;
		c = 0;
		do begin
			@(negedge __wls_1);
			compare({tag, " no read before halt"}, 0, rd);
			compare({tag, " no register write"}, 0, w_r);
			compare({tag, " no jump"}, 0, w_ic);
			c++;
		end while (run && c < 12);
		compare({tag, " run after halt"}, 0, run);
		pause = $urandom_range(2, 6);
		repeat (pause) begin
			@(negedge __wls_1);
			compare({tag, " no read while stopped"}, 0, rd);
			compare({tag, " run while stopped"}, 0, run);
		end
		raise_start();
	endtask

	task automatic execute_one(input int idx);
		string    tag;
		word_t    iw;
		word_t    n;
		opcode_t  opc;
		reg_sel_t fa;
		reg_sel_t fb;
		reg_sel_t fc;
		tag = $sformatf("instr %0d", idx);
		read_check({tag, " fetch"}, model_ic);
		iw = mem[model_ic[7:0]];
		model_ic = model_ic + 16'd1;
		opc = iw[15:10];
		fa = iw[8:6];
		fb = iw[5:3];
		fc = iw[2:0];
		// normal argument from the second word or Rc, then plus Rb
		if (fc == 3'd0) begin
			read_check({tag, " arg"}, model_ic);
			n = mem[model_ic[7:0]];
			model_ic = model_ic + 16'd1;
			cov[7]++;
		end else begin
			n = model_regs[fc];
		end
		if (fb != 3'd0) begin
			n = n + model_regs[fb];
			cov[8]++;
		end
		case (opc)
			op_lw: begin
				reg_write_check({tag, " lw"}, fa, n);
				cov[0]++;
			end
			op_aw: begin
				reg_write_check({tag, " aw"}, fa, model_regs[fa] + n);
				cov[1]++;
			end
			op_nr: begin
				reg_write_check({tag, " nr"}, fa, model_regs[fa] & n);
				cov[2]++;
			end
			op_er: begin
				reg_write_check({tag, " er"}, fa, model_regs[fa] ^ n);
				cov[3]++;
			end
			op_uj: begin
				jump_check({tag, " uj"}, n);
				cov[4]++;
			end
			op_hlt: begin
				halt_and_resume({tag, " hlt"});
				cov[5]++;
			end
			// nothing written, the next fetch must come first
			default: cov[6]++;
		endcase
	endtask

	initial begin
		start = 1'b0;
		__m77 = 1'b1;
		checks = 0;
		errors = 0;
		tests = 0;
		cur_test = "";
		seed_val = $urandom(seed);
		model_ic = '0;
		foreach (model_regs[i])
			model_regs[i] = '0;
		foreach (cov[i])
			cov[i] = 0;
		build_program();
		repeat (reset_cycles) @(posedge __wls_1);
		__m77 <= 1'b0;

		begin_test("idle_after_reset");
		repeat (idle_cycles) begin
			@(negedge __wls_1);
			compare("idle run", 0, run);
			compare("idle rd", 0, rd);
			compare("idle w_r", 0, w_r);
			compare("idle w_ic", 0, w_ic);
		end
		end_test();

		begin_test("random_program");
		raise_start();
		for (int k = 0; k < n_instr; k++)
			execute_one(k);
		read_check("final fetch", model_ic);
		end_test();

		begin_test("operation_coverage");
		foreach (cov[i]) begin
			if (cov[i] == 0) begin
				errors++;
				$display("Coverage hole: no %s case was executed", cov_names[i]);
			end
		end
		end_test();

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
hw/mera_pkg.sv
hw/ctl_seq.sv
hw/reg_file.sv
hw/alu.sv
hw/ic_ar.sv
hw/w_bus_sel.sv
hw/cpu_top.sv
dv/tb_cpu.sv

// File: Makefile
# Verilator simulation of the cut-down MERA-400 control path

VERILATOR ?= verilator
TOP       ?= tb_cpu
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
